// ==== hw/cart_cfg.svh ====
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// ROM side of the cartridge bus, byte wide only
`define ROM_AW 24

// battery-backed save RAM
`define BSRAM_AW 20

// CPU and memory data width
`define DW 8

// MSU register window start, 8 registers from here
`define MSU_BASE 16'h2000

// flash pack write-enable register, banks $00-$0F
`define FLASH_REG 16'h5000

`endif

// ==== hw/snes_bus_pkg.sv ====
`include "cart_cfg.svh"

package snes_bus_pkg;

  // CPU side of the cartridge slot, as seen by the mappers
  typedef struct packed {
    logic [`ROM_AW-1:0] ca;
    logic               cpurd_n;
    logic               cpuwr_n;
    logic               romsel_n;
    logic               ramsel_n;
    // write data from the CPU
    logic [`DW-1:0]     dout;
    logic               sysclkf_ce;
  } cpu_bus_t;

  // ROM strobes, we_n only ever drops for flash writes
  typedef struct packed {
    logic [`ROM_AW-1:0] addr;
    logic [`DW-1:0]     d;
    logic               ce_n;
    logic               oe_n;
    logic               we_n;
  } rom_bus_t;

  typedef struct packed {
    logic [`BSRAM_AW-1:0] addr;
    logic [`DW-1:0]       d;
    logic                 ce_n;
    logic                 oe_n;
    logic                 we_n;
  } bsram_bus_t;

endpackage

// ==== hw/cart_pkg.sv ====
`include "cart_cfg.svh"

package cart_pkg;
  import snes_bus_pkg::*;

  // rom_type[7:4]
  typedef enum logic [3:0] {
    CHIP_NONE  = 4'h0,
    CHIP_FLASH = 4'h3
  } chip_e;

  // rom_type[0]
  typedef enum logic {
    LAYOUT_LO = 1'b0,
    LAYOUT_HI = 1'b1
  } layout_e;

  // read offsets; the write registers share offsets 4 to 6
  typedef enum logic [2:0] {
    STATUS = 3'd0,
    ID0    = 3'd2,
    ID1    = 3'd3,
    ID2    = 3'd4,
    ID3    = 3'd5,
    ID4    = 3'd6,
    ID5    = 3'd7
  } msu_reg_e;

  localparam msu_reg_e TRACK_LO = ID2;
  localparam msu_reg_e TRACK_HI = ID3;
  localparam msu_reg_e VOLUME   = ID4;

  typedef struct packed {
    rom_bus_t       rom;
    bsram_bus_t     bsram;
    logic [`DW-1:0] di;
    logic           di_valid;
  } mapper_out_t;

  // LoROM save RAM, banks $70-$7D below $8000
  function automatic logic lo_bsram_hit(input logic [`ROM_AW-1:0] ca);
    return (ca[23:16] >= 8'h70) && (ca[23:16] <= 8'h7D) && !ca[15];
  endfunction

  // 32K pages, A15 dropped
  function automatic logic [`ROM_AW-1:0] lo_rom_addr(input logic [`ROM_AW-1:0] ca,
                                                     input logic [`ROM_AW-1:0] mask);
    return {2'b00, ca[22:16], ca[14:0]} & mask;
  endfunction

  function automatic logic [`BSRAM_AW-1:0] lo_bsram_addr(input logic [`ROM_AW-1:0] ca,
                                                         input logic [`BSRAM_AW-1:0] mask);
    return {1'b0, ca[19:16], ca[14:0]} & mask;
  endfunction

endpackage

// ==== hw/lhrom_mapper.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

module lhrom_mapper
  import snes_bus_pkg::*;
  import cart_pkg::*;
(
  input  logic                 mclk,
  input  logic                 rst_n,
  input  cpu_bus_t             cpu,
  input  logic [7:0]           rom_type,
  input  logic [`ROM_AW-1:0]   rom_mask,
  input  logic [`BSRAM_AW-1:0] ram_mask,
  input  logic [`DW-1:0]       rom_q,
  input  logic [`DW-1:0]       bsram_q,
  output mapper_out_t          out
);

  layout_e    layout;
  logic [7:0] bank;
  logic       hi_bsram_hit;
  logic       bsram_hit;
  logic       rom_hit;

  assign layout = layout_e'(rom_type[0]);
  assign bank   = cpu.ca[23:16];

  // hirom sram at $6000-$7FFF in banks $20-$3F and $A0-$BF
  assign hi_bsram_hit = (bank[6:5] == 2'b01) && (cpu.ca[15:13] == 3'b011);
  assign bsram_hit    = (layout == LAYOUT_HI) ? hi_bsram_hit : lo_bsram_hit(cpu.ca);
  assign rom_hit      = !cpu.romsel_n && !bsram_hit;

  always_comb begin
    out = '0;
    if (layout == LAYOUT_HI) begin
      out.rom.addr   = {2'b00, cpu.ca[21:0]} & rom_mask;
      out.bsram.addr = {2'b00, cpu.ca[20:16], cpu.ca[12:0]} & ram_mask;
    end else begin
      out.rom.addr   = lo_rom_addr(cpu.ca, rom_mask);
      out.bsram.addr = lo_bsram_addr(cpu.ca, ram_mask);
    end

    // plain mask ROM, never written
    out.rom.d    = '0;
    out.rom.ce_n = !rom_hit;
    out.rom.oe_n = cpu.cpurd_n;
    out.rom.we_n = 1'b1;

    out.bsram.d    = cpu.dout;
    out.bsram.ce_n = !bsram_hit;
    out.bsram.oe_n = cpu.cpurd_n;
    out.bsram.we_n = !(bsram_hit && !cpu.cpuwr_n);

    if (!cpu.cpurd_n) begin
      if (rom_hit) begin
        out.di       = rom_q;
        out.di_valid = 1'b1;
      end else if (bsram_hit) begin
        out.di       = bsram_q;
        out.di_valid = 1'b1;
      end
    end
  end

  a_one_chip: assert property (@(posedge mclk) disable iff (!rst_n)
    !(!out.rom.ce_n && !out.bsram.ce_n));

endmodule

// ==== hw/flash_mapper.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

module flash_mapper
  import snes_bus_pkg::*;
  import cart_pkg::*;
(
  input  logic                 mclk,
  input  logic                 rst_n,
  input  cpu_bus_t             cpu,
  input  logic [7:0]           rom_type,
  input  logic [`ROM_AW-1:0]   rom_mask,
  input  logic [`BSRAM_AW-1:0] ram_mask,
  input  logic [`DW-1:0]       rom_q,
  input  logic [`DW-1:0]       bsram_q,
  output mapper_out_t          out,
  output logic                 flash_active
);

  logic write_en;
  logic reg_hit;
  logic bsram_hit;
  logic rom_hit;
  logic rom_wr;

  assign flash_active = (chip_e'(rom_type[7:4]) == CHIP_FLASH);

  // control register lives in banks $00-$0F only
  assign reg_hit   = (cpu.ca[23:20] == 4'h0) && (cpu.ca[15:0] == `FLASH_REG);
  assign bsram_hit = lo_bsram_hit(cpu.ca);
  assign rom_hit   = !cpu.romsel_n && !bsram_hit;
  assign rom_wr    = rom_hit && !cpu.cpuwr_n && write_en;

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      write_en <= 1'b0;
    end else if (cpu.sysclkf_ce && !cpu.cpuwr_n && reg_hit) begin
      write_en <= cpu.dout[0];
    end
  end

  always_comb begin
    out = '0;

    out.rom.addr = lo_rom_addr(cpu.ca, rom_mask);
    out.rom.d    = cpu.dout;
    // chip is selected for a write even when it is locked
    out.rom.ce_n = !rom_hit;
    out.rom.oe_n = cpu.cpurd_n;
    out.rom.we_n = !rom_wr;

    out.bsram.addr = lo_bsram_addr(cpu.ca, ram_mask);
    out.bsram.d    = cpu.dout;
    out.bsram.ce_n = !bsram_hit;
    out.bsram.oe_n = cpu.cpurd_n;
    out.bsram.we_n = !(bsram_hit && !cpu.cpuwr_n);

    if (!cpu.cpurd_n) begin
      if (reg_hit) begin
        out.di       = {{(`DW-1){1'b0}}, write_en};
        out.di_valid = 1'b1;
      end else if (rom_hit) begin
        out.di       = rom_q;
        out.di_valid = 1'b1;
      end else if (bsram_hit) begin
        out.di       = bsram_q;
        out.di_valid = 1'b1;
      end
    end
  end

  a_locked: assert property (@(posedge mclk) disable iff (!rst_n)
    !out.rom.we_n |-> write_en);

endmodule

// ==== hw/msu_regs.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

module msu_regs
  import snes_bus_pkg::*;
  import cart_pkg::*;
(
  input  logic           mclk,
  input  logic           rst_n,
  input  cpu_bus_t       cpu,
  input  logic           msu_enable,
  input  logic           msu_track_mounting,
  input  logic           msu_track_missing,
  output logic           msu_sel,
  output logic [`DW-1:0] msu_do,
  output logic [15:0]    msu_track_num,
  output logic           msu_track_request,
  output logic [7:0]     msu_volume
);

  msu_reg_e reg_off;
  logic     in_window;
  logic     wr_take;
  logic     hi_take;
  logic     hi_take_q;

  // system area banks only, $2000-$2007
  assign in_window = msu_enable && !cpu.ca[22] &&
                     ((cpu.ca[15:0] & 16'hFFF8) == `MSU_BASE);
  assign reg_off   = msu_reg_e'(cpu.ca[2:0]);
  assign msu_sel   = in_window && !cpu.cpurd_n;
  assign wr_take   = in_window && cpu.sysclkf_ce && !cpu.cpuwr_n;
  assign hi_take   = wr_take && (reg_off == TRACK_HI);

  always_comb begin
    case (reg_off)
      // revision 1 in the low bits
      STATUS:  msu_do = {1'b0, msu_track_mounting, 2'b00, msu_track_missing, 3'd1};
      ID0:     msu_do = 8'h53;
      ID1:     msu_do = 8'h2D;
      ID2:     msu_do = 8'h4D;
      ID3:     msu_do = 8'h53;
      ID4:     msu_do = 8'h55;
      ID5:     msu_do = 8'h31;
      default: msu_do = 8'h00;
    endcase
  end

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      msu_track_num     <= 16'h0000;
      msu_volume        <= 8'h00;
      msu_track_request <= 1'b0;
      hi_take_q         <= 1'b0;
    end else begin
      hi_take_q <= hi_take;
      // one pulse per track write, even if the strobe is held
      msu_track_request <= hi_take && !hi_take_q;
      if (wr_take) begin
        case (reg_off)
          TRACK_LO: msu_track_num[7:0]  <= cpu.dout;
          TRACK_HI: msu_track_num[15:8] <= cpu.dout;
          VOLUME:   msu_volume          <= cpu.dout;
          default:  ;
        endcase
      end
    end
  end

  a_req_pulse: assert property (@(posedge mclk) disable iff (!rst_n)
    msu_track_request |=> !msu_track_request);

endmodule

// ==== hw/cart_arbiter.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

module cart_arbiter
  import snes_bus_pkg::*;
  import cart_pkg::*;
(
  input  mapper_out_t    lh,
  input  mapper_out_t    fl,
  input  logic           flash_active,
  input  logic           msu_sel,
  input  logic [`DW-1:0] msu_do,
  input  logic           mclk,
  output rom_bus_t       rom,
  output bsram_bus_t     bsram,
  output logic [`DW-1:0] cpu_di
);

  mapper_out_t grant;

  // base mapper owns the buses unless a flash pack is loaded
  assign grant = flash_active ? fl : lh;
  assign rom   = grant.rom;
  assign bsram = grant.bsram;

  always_comb begin
    if (msu_sel) begin
      cpu_di = msu_do;
    end else if (grant.di_valid) begin
      cpu_di = grant.di;
    end else begin
      cpu_di = '0;
    end
  end

  // msu window is outside ROM space in every layout
  a_msu_no_rom: assert property (@(posedge mclk) msu_sel |-> rom.ce_n);

endmodule

// ==== hw/cart_bus_top.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

module cart_bus_top
  import snes_bus_pkg::*;
  import cart_pkg::*;
(
  input  logic                 mclk,
  input  logic                 rst_n,
  input  cpu_bus_t             cpu,
  input  logic [7:0]           rom_type,
  input  logic [`ROM_AW-1:0]   rom_mask,
  input  logic [`BSRAM_AW-1:0] ram_mask,
  input  logic [`DW-1:0]       rom_q,
  input  logic [`DW-1:0]       bsram_q,
  input  logic                 msu_enable,
  input  logic                 msu_track_mounting,
  input  logic                 msu_track_missing,
  output rom_bus_t             rom,
  output bsram_bus_t           bsram,
  output logic [`DW-1:0]       cpu_di,
  output logic [15:0]          msu_track_num,
  output logic                 msu_track_request,
  output logic [7:0]           msu_volume
);

  mapper_out_t    lh_out;
  mapper_out_t    fl_out;
  logic           flash_active;
  logic           msu_sel;
  logic [`DW-1:0] msu_do;

  lhrom_mapper u_lhrom (
    .mclk     (mclk),
    .rst_n    (rst_n),
    .cpu      (cpu),
    .rom_type (rom_type),
    .rom_mask (rom_mask),
    .ram_mask (ram_mask),
    .rom_q    (rom_q),
    .bsram_q  (bsram_q),
    .out      (lh_out)
  );

  flash_mapper u_flash (
    .mclk         (mclk),
    .rst_n        (rst_n),
    .cpu          (cpu),
    .rom_type     (rom_type),
    .rom_mask     (rom_mask),
    .ram_mask     (ram_mask),
    .rom_q        (rom_q),
    .bsram_q      (bsram_q),
    .out          (fl_out),
    .flash_active (flash_active)
  );

  msu_regs u_msu (
    .mclk               (mclk),
    .rst_n              (rst_n),
    .cpu                (cpu),
    .msu_enable         (msu_enable),
    .msu_track_mounting (msu_track_mounting),
    .msu_track_missing  (msu_track_missing),
    .msu_sel            (msu_sel),
    .msu_do             (msu_do),
    .msu_track_num      (msu_track_num),
    .msu_track_request  (msu_track_request),
    .msu_volume         (msu_volume)
  );

  cart_arbiter u_arb (
    .lh           (lh_out),
    .fl           (fl_out),
    .flash_active (flash_active),
    .msu_sel      (msu_sel),
    .msu_do       (msu_do),
    .mclk         (mclk),
    .rom          (rom),
    .bsram        (bsram),
    .cpu_di       (cpu_di)
  );

endmodule

// ==== sim/cart_bus_tb.sv ====
`timescale 1ns/1ps

module cart_bus_tb
  import snes_bus_pkg::*;
();

  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 10;
  localparam int N_RAND       = 16;
  // two clocks per access, six random accesses per loop index plus the fixed ones
  localparam int ACCESSES     = 6 * N_RAND + 24;
  localparam int MARGIN       = 50;

  logic        mclk;
  logic        rst_n;
  cpu_bus_t    cpu;
  logic [7:0]  rom_type;
  logic [23:0] rom_mask;
  logic [19:0] ram_mask;
  logic [7:0]  rom_q;
  logic [7:0]  bsram_q;
  logic        msu_enable;
  logic        msu_track_mounting;
  logic        msu_track_missing;
  rom_bus_t    rom;
  bsram_bus_t  bsram;
  logic [7:0]  cpu_di;
  logic [15:0] msu_track_num;
  logic        msu_track_request;
  logic [7:0]  msu_volume;

  integer seed;
  int     checks;
  int     errors;
  int     errors_at_start;
  int     n_tests;
  string  test_name;

  // memory models answer in the same cycle
  assign rom_q   = rom.addr[7:0] ^ 8'h5A;
  assign bsram_q = bsram.addr[7:0] ^ 8'h5A;

  cart_bus_top UUT (
    .mclk               (mclk),
    .rst_n              (rst_n),
    .cpu                (cpu),
    .rom_type           (rom_type),
    .rom_mask           (rom_mask),
    .ram_mask           (ram_mask),
    .rom_q              (rom_q),
    .bsram_q            (bsram_q),
    .msu_enable         (msu_enable),
    .msu_track_mounting (msu_track_mounting),
    .msu_track_missing  (msu_track_missing),
    .rom                (rom),
    .bsram              (bsram),
    .cpu_di             (cpu_di),
    .msu_track_num      (msu_track_num),
    .msu_track_request  (msu_track_request),
    .msu_volume         (msu_volume)
  );

  initial begin
    mclk = 1'b0;
    forever #(PERIOD / 2) mclk = ~mclk;
  end

  a_idle_we: assert property (@(posedge mclk) disable iff (!rst_n)
    cpu.cpuwr_n |-> (rom.we_n && bsram.we_n))
    else begin
      errors++;
      $display("** Error: %s a write strobe went low without a CPU write", test_name);
    end

  a_req_once: assert property (@(posedge mclk) disable iff (!rst_n)
    msu_track_request |=> !msu_track_request)
    else begin
      errors++;
      $display("** Error: %s track request stayed high for two cycles", test_name);
    end

  task automatic check(input string what, input logic [23:0] exp, input logic [23:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("** Error: %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // ROM space is the upper half of system banks and all of $40-$7D and $C0-$FF
  function automatic logic romsel_n_for(input logic [23:0] ca);
    if (ca[22]) begin
      return ca[23:17] == 7'b0111111;
    end
    return !ca[15];
  endfunction

  task automatic start_access(input logic [23:0] ca, input logic wr, input logic [7:0] data);
    @(negedge mclk);
    cpu.ca         = ca;
    cpu.romsel_n   = romsel_n_for(ca);
    cpu.cpurd_n    = wr;
    cpu.cpuwr_n    = !wr;
    cpu.dout       = data;
    cpu.sysclkf_ce = 1'b1;
    // decode is combinational, give it a moment
    #5;
  endtask

  task automatic end_access();
    @(negedge mclk);
    cpu.cpurd_n    = 1'b1;
    cpu.cpuwr_n    = 1'b1;
    cpu.romsel_n   = 1'b1;
    cpu.sysclkf_ce = 1'b0;
  endtask

  task automatic bsram_rw(input logic [23:0] ca, input logic [23:0] exp, input logic [7:0] data);
    start_access(ca, 1'b1, data);
    check("bsram addr", exp, bsram.addr);
    check("bsram ce_n", 0, bsram.ce_n);
    check("bsram we_n", 0, bsram.we_n);
    check("bsram d", data, bsram.d);
    check("rom ce_n", 1, rom.ce_n);
    end_access();
    start_access(ca, 1'b0, 8'h00);
    check("bsram we_n", 1, bsram.we_n);
    check("cpu_di", exp[7:0] ^ 8'h5A, cpu_di);
    end_access();
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    n_tests++;
  endtask

  task automatic end_test();
    $display("test %-12s %0d errors", test_name, errors - errors_at_start);
  endtask

  initial begin
    #((RESET_CYCLES + 2 * ACCESSES + MARGIN) * PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Something failed");
    $finish;
  end

  initial begin
    logic [23:0] ca;
    logic [23:0] exp;
    logic [7:0]  data;
    logic [31:0] rnd;
    string       id;

    seed               = 70;
    checks             = 0;
    errors             = 0;
    n_tests            = 0;
    rst_n              = 1'b0;
    cpu                = '0;
    cpu.cpurd_n        = 1'b1;
    cpu.cpuwr_n        = 1'b1;
    cpu.romsel_n       = 1'b1;
    cpu.ramsel_n       = 1'b1;
    rom_type           = 8'h00;
    rom_mask           = 24'h1FFFFF;
    ram_mask           = 20'h07FFF;
    msu_enable         = 1'b0;
    msu_track_mounting = 1'b0;
    msu_track_missing  = 1'b0;

    begin_test("reset");
    repeat (RESET_CYCLES) @(negedge mclk);
    rst_n = 1'b1;
    #5;
    check("track_request", 0, msu_track_request);
    check("track_num", 0, msu_track_num);
    check("volume", 0, msu_volume);
    check("rom we_n", 1, rom.we_n);
    check("bsram we_n", 1, bsram.we_n);
    rom_type = 8'h30;
    start_access(24'h005000, 1'b0, 8'h00);
    check("flash enable", 0, cpu_di);
    end_access();
    rom_type = 8'h00;
    end_test();

    begin_test("lorom_read");
    for (int i = 0; i < N_RAND; i++) begin
      rnd    = $random(seed);
      ca     = rnd[23:0];
      ca[15] = 1'b1;
      // stay out of the WRAM banks
      if (ca[22:17] == 6'b111111) ca[22] = 1'b0;
      exp = {2'b00, ca[22:16], ca[14:0]} & rom_mask;
      start_access(ca, 1'b0, 8'h00);
      check("rom addr", exp, rom.addr);
      check("rom ce_n", 0, rom.ce_n);
      check("rom oe_n", 0, rom.oe_n);
      check("cpu_di", exp[7:0] ^ 8'h5A, cpu_di);
      end_access();
    end
    end_test();

    begin_test("hirom_bsram");
    rom_type = 8'h01;
    rom_mask = 24'h0FFFFF;
    ram_mask = 20'h3FFFF;
    for (int i = 0; i < N_RAND; i++) begin
      rnd        = $random(seed);
      ca         = rnd[23:0];
      ca[23:22]  = 2'b11;
      exp = {2'b00, ca[21:0]} & rom_mask;
      start_access(ca, 1'b0, 8'h00);
      check("rom addr", exp, rom.addr);
      check("rom ce_n", 0, rom.ce_n);
      check("rom we_n", 1, rom.we_n);
      check("cpu_di", exp[7:0] ^ 8'h5A, cpu_di);
      end_access();
    end
    for (int i = 0; i < N_RAND; i++) begin
      rnd       = $random(seed);
      ca        = rnd[23:0];
      ca[22:21] = 2'b01;
      ca[15:13] = 3'b011;
      data      = rnd[31:24];
      exp = {6'b0, ca[20:16], ca[12:0]} & {4'h0, ram_mask};
      bsram_rw(ca, exp, data);
    end
    rom_type = 8'h00;
    ram_mask = 20'h7FFFF;
    for (int i = 0; i < N_RAND; i++) begin
      rnd       = $random(seed);
      ca        = rnd[23:0];
      ca[23:16] = 8'h70 + (ca[23:16] % 8'd14);
      ca[15]    = 1'b0;
      data      = rnd[31:24];
      exp = {5'b0, ca[19:16], ca[14:0]} & {4'h0, ram_mask};
      bsram_rw(ca, exp, data);
    end
    end_test();

    begin_test("flash");
    rom_type = 8'h30;
    rom_mask = 24'h1FFFFF;
    rnd      = $random(seed);
    ca       = {8'h03, 1'b1, rnd[14:0]};
    data     = rnd[31:24];
    exp      = {2'b00, ca[22:16], ca[14:0]} & rom_mask;
    start_access(ca, 1'b1, data);
    check("locked we_n", 1, rom.we_n);
    check("rom ce_n", 0, rom.ce_n);
    end_access();
    start_access(24'h005000, 1'b1, 8'h01);
    end_access();
    start_access(24'h005000, 1'b0, 8'h00);
    check("enable read", 1, cpu_di);
    end_access();
    start_access(ca, 1'b1, data);
    check("rom addr", exp, rom.addr);
    check("rom we_n", 0, rom.we_n);
    check("rom d", data, rom.d);
    end_access();
    // bank $0F still reaches the register
    start_access(24'h0F5000, 1'b1, 8'hFE);
    end_access();
    start_access(24'h005000, 1'b0, 8'h00);
    check("enable read", 0, cpu_di);
    end_access();
    start_access(ca, 1'b1, data);
    check("locked we_n", 1, rom.we_n);
    end_access();
    rom_type = 8'h00;
    end_test();

    begin_test("msu_write");
    msu_enable = 1'b1;
    rnd        = $random(seed);
    start_access(24'h002004, 1'b1, rnd[7:0]);
    end_access();
    start_access(24'h802005, 1'b1, rnd[15:8]);
    end_access();
    check("track_request", 1, msu_track_request);
    @(negedge mclk);
    check("track_request", 0, msu_track_request);
    check("track_num", rnd[15:0], msu_track_num);
    start_access(24'h002006, 1'b1, rnd[23:16]);
    end_access();
    check("volume", rnd[23:16], msu_volume);
    end_test();

    begin_test("msu_read");
    id = "S-MSU1";
    for (int i = 0; i < 6; i++) begin
      start_access(24'h002002 + 24'(i), 1'b0, 8'h00);
      check("id byte", id[i], cpu_di);
      end_access();
    end
    for (int i = 0; i < 4; i++) begin
      msu_track_mounting = i[0];
      msu_track_missing  = i[1];
      start_access(24'h802000, 1'b0, 8'h00);
      check("status", {1'b0, i[0], 2'b00, i[1], 3'd1}, cpu_di);
      end_access();
    end
    msu_enable = 1'b0;
    start_access(24'h002002, 1'b0, 8'h00);
    check("disabled read", 0, cpu_di);
    end_access();
    end_test();

    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== cart_bus_top.f ====
+incdir+hw
hw/snes_bus_pkg.sv
hw/cart_pkg.sv
hw/lhrom_mapper.sv
hw/flash_mapper.sv
hw/msu_regs.sv
hw/cart_arbiter.sv
hw/cart_bus_top.sv
sim/cart_bus_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= cart_bus_top.f
TB_TOP    ?= cart_bus_tb
RTL_TOP   ?= cart_bus_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
